/* src/vec_pkg.sv */
package vec_pkg;

    ////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////

    // Element width of both input vectors
    localparam int DATA_W = 16;

    // Width of the result bus, all results zero-extended to this
    localparam int RESULT_W = 32;

    // Manhattan accumulator wraps at this width
    localparam int MAN_W = 24;

    ////////////////////////////////////////////////////////////
    // Vector length
    ////////////////////////////////////////////////////////////

    // Length field, a value of zero selects MAX_LEN
    localparam int LEN_W = 10;
    localparam int MAX_LEN = 1024;

    // One root bit per iteration, half the radicand width
    localparam int SQRT_ITERS = 16;

    ////////////////////////////////////////////////////////////
    // Operations
    ////////////////////////////////////////////////////////////

    // Encoding order matches the one-hot enables bit order
    typedef enum logic [2:0] {
        OP_READ = 3'd0,
        OP_SUM  = 3'd1,
        OP_AVG  = 3'd2,
        OP_EUC  = 3'd3,
        OP_MAN  = 3'd4,
        OP_DOT  = 3'd5
    } op_e;

endpackage

/* src/op_config.sv */
`timescale 1ns/1ps

module op_config (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cfg_write,
    input  vec_pkg::op_e                cfg_op,
    input  logic [vec_pkg::LEN_W-1:0]   cfg_len,
    input  logic                        data_valid,
    input  logic                        busy,
    output vec_pkg::op_e                op,
    output logic [5:0]                  enables,
    output logic                        elem_strobe,
    output logic                        first,
    output logic                        last
);

    logic [vec_pkg::LEN_W-1:0] len_q;
    logic [vec_pkg::LEN_W-1:0] count_q;
    logic [vec_pkg::LEN_W-1:0] last_idx;

    ////////////////////////////////////////////////////////////
    // Configuration and element counter
    ////////////////////////////////////////////////////////////

    // Strobes seen while the square root runs are dropped
    assign elem_strobe = data_valid && !busy;

    // Zero length stands for a full vector
    assign last_idx = (len_q == '0) ? vec_pkg::LEN_W'(vec_pkg::MAX_LEN - 1)
                                    : len_q - 1'b1;

    assign first = (count_q == '0);
    assign last  = (count_q == last_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            op      <= vec_pkg::OP_READ;
            len_q   <= '0;
            count_q <= '0;
        end else if (cfg_write) begin
            // New config abandons any vector in progress
            op      <= cfg_op;
            len_q   <= cfg_len;
            count_q <= '0;
        end else if (elem_strobe) begin
            if (last) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // One-hot decode, bit order read sum avg euc man dot
    ////////////////////////////////////////////////////////////

    always_comb begin
        enables = '0;
        case (op)
            vec_pkg::OP_READ: enables[0] = 1'b1;
            vec_pkg::OP_SUM:  enables[1] = 1'b1;
            vec_pkg::OP_AVG:  enables[2] = 1'b1;
            vec_pkg::OP_EUC:  enables[3] = 1'b1;
            vec_pkg::OP_MAN:  enables[4] = 1'b1;
            vec_pkg::OP_DOT:  enables[5] = 1'b1;
            default:          enables    = '0;
        endcase
    end

endmodule

/* src/elem_ops.sv */
`timescale 1ns/1ps

module elem_ops (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [2:0]                  enables,
    input  logic                        elem_strobe,
    input  logic                        src_sel,
    input  logic [vec_pkg::DATA_W-1:0]  data_a,
    input  logic [vec_pkg::DATA_W-1:0]  data_b,
    output logic [vec_pkg::DATA_W-1:0]  elem_result,
    output logic                        elem_valid
);

    // One extra bit keeps the carry for the average
    logic [vec_pkg::DATA_W:0]   wide_sum;
    logic [vec_pkg::DATA_W-1:0] op_value;

    assign wide_sum = {1'b0, data_a} + {1'b0, data_b};

    ////////////////////////////////////////////////////////////
    // Element-wise operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (enables[0]) begin
            op_value = src_sel ? data_b : data_a;
        end else if (enables[1]) begin
            // Sum wraps at the element width
            op_value = wide_sum[vec_pkg::DATA_W-1:0];
        end else if (enables[2]) begin
            // Floor of the halved 17-bit sum
            op_value = wide_sum[vec_pkg::DATA_W:1];
        end else begin
            op_value = '0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (elem_strobe) begin
            elem_result <= op_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            elem_valid <= 1'b0;
        end else begin
            elem_valid <= elem_strobe && (|enables);
        end
    end

endmodule

/* src/vec_accum.sv */
`timescale 1ns/1ps

module vec_accum (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cfg_write,
    input  logic [2:0]                    enables,
    input  logic                          elem_strobe,
    input  logic                          first,
    input  logic                          last,
    input  logic [vec_pkg::DATA_W-1:0]    data_a,
    input  logic [vec_pkg::DATA_W-1:0]    data_b,
    output logic [vec_pkg::MAN_W-1:0]     man_sum,
    output logic [vec_pkg::RESULT_W-1:0]  dot_sum,
    output logic [vec_pkg::RESULT_W-1:0]  sq_sum,
    output logic                          accum_done
);

    logic [vec_pkg::DATA_W-1:0]   abs_diff;
    logic [vec_pkg::MAN_W-1:0]    man_term;
    logic [vec_pkg::RESULT_W-1:0] dot_term;
    logic [vec_pkg::RESULT_W-1:0] sq_term;
    logic [vec_pkg::MAN_W-1:0]    man_acc;
    logic [vec_pkg::RESULT_W-1:0] dot_acc;
    logic [vec_pkg::RESULT_W-1:0] sq_acc;
    logic                         last_hit;

    ////////////////////////////////////////////////////////////
    // Per-element terms
    ////////////////////////////////////////////////////////////

    assign abs_diff = (data_a >= data_b) ? data_a - data_b : data_b - data_a;
    assign man_term = {{(vec_pkg::MAN_W - vec_pkg::DATA_W){1'b0}}, abs_diff};
    assign dot_term = data_a * data_b;
    assign sq_term  = abs_diff * abs_diff;

    ////////////////////////////////////////////////////////////
    // Running sums, first element loads instead of adding
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cfg_write) begin
            man_acc <= '0;
            dot_acc <= '0;
            sq_acc  <= '0;
        end else if (elem_strobe) begin
            if (enables[0]) begin
                sq_acc <= first ? sq_term : sq_acc + sq_term;
            end
            if (enables[1]) begin
                man_acc <= first ? man_term : man_acc + man_term;
            end
            if (enables[2]) begin
                dot_acc <= first ? dot_term : dot_acc + dot_term;
            end
        end
    end

    // Snapshot so a back-to-back vector can restart the running sums
    always_ff @(posedge clk) begin
        if (cfg_write) begin
            man_sum <= '0;
            dot_sum <= '0;
            sq_sum  <= '0;
        end else if (last_hit) begin
            man_sum <= man_acc;
            dot_sum <= dot_acc;
            sq_sum  <= sq_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || cfg_write) begin
            last_hit   <= 1'b0;
            accum_done <= 1'b0;
        end else begin
            last_hit   <= elem_strobe && last && (|enables);
            accum_done <= last_hit;
        end
    end

endmodule

/* src/int_sqrt.sv */
`timescale 1ns/1ps

module int_sqrt (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [vec_pkg::RESULT_W-1:0]  radicand,
    output logic [vec_pkg::DATA_W-1:0]    root,
    output logic                          busy,
    output logic                          sqrt_done
);

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_e;

    state_e state_q;

    logic [4:0]                   iter_q;
    logic [vec_pkg::RESULT_W-1:0] rad_q;
    // Partial remainder, MSB is the sign
    logic [vec_pkg::DATA_W+3:0]   rem_q;
    logic [vec_pkg::DATA_W+3:0]   rem_shift;
    logic [vec_pkg::DATA_W+3:0]   rem_next;

    ////////////////////////////////////////////////////////////
    // Non-restoring step, two radicand bits per root bit
    ////////////////////////////////////////////////////////////

    always_comb begin
        rem_shift = {rem_q[vec_pkg::DATA_W+1:0], rad_q[vec_pkg::RESULT_W-1 -: 2]};
        if (!rem_q[vec_pkg::DATA_W+3]) begin
            rem_next = rem_shift - {2'b00, root, 2'b01};
        end else begin
            rem_next = rem_shift + {2'b00, root, 2'b11};
        end
    end

    // Start counts as busy so the same cycle already blocks strobes
    assign busy = (state_q == S_RUN) || start;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= S_IDLE;
            iter_q    <= '0;
            sqrt_done <= 1'b0;
        end else begin
            sqrt_done <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start) begin
                        state_q <= S_RUN;
                        iter_q  <= '0;
                    end
                end
                S_RUN: begin
                    iter_q <= iter_q + 1'b1;
                    if (iter_q == 5'(vec_pkg::SQRT_ITERS - 1)) begin
                        state_q   <= S_IDLE;
                        sqrt_done <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start) begin
            rad_q <= radicand;
            rem_q <= '0;
            root  <= '0;
        end else if (state_q == S_RUN) begin
            rad_q <= {rad_q[vec_pkg::RESULT_W-3:0], 2'b00};
            rem_q <= rem_next;
            root  <= {root[vec_pkg::DATA_W-2:0], ~rem_next[vec_pkg::DATA_W+3]};
        end
    end

endmodule

/* src/result_select.sv */
`timescale 1ns/1ps

module result_select (
    input  logic                          clk,
    input  logic                          rst,
    input  vec_pkg::op_e                  op,
    input  logic [vec_pkg::DATA_W-1:0]    elem_result,
    input  logic                          elem_valid,
    input  logic [vec_pkg::MAN_W-1:0]     man_sum,
    input  logic [vec_pkg::RESULT_W-1:0]  dot_sum,
    input  logic                          accum_done,
    input  logic [vec_pkg::DATA_W-1:0]    root,
    input  logic                          sqrt_done,
    output logic [vec_pkg::RESULT_W-1:0]  result,
    output logic                          result_valid
);

    logic [vec_pkg::RESULT_W-1:0] sel_value;
    logic                         sel_fire;

    // Source and valid event follow the held operation
    always_comb begin
        case (op)
            vec_pkg::OP_EUC: begin
                sel_value = {{(vec_pkg::RESULT_W - vec_pkg::DATA_W){1'b0}}, root};
                sel_fire  = sqrt_done;
            end
            vec_pkg::OP_MAN: begin
                sel_value = {{(vec_pkg::RESULT_W - vec_pkg::MAN_W){1'b0}}, man_sum};
                sel_fire  = accum_done;
            end
            vec_pkg::OP_DOT: begin
                sel_value = dot_sum;
                sel_fire  = accum_done;
            end
            default: begin
                // read, sum and average
                sel_value = {{(vec_pkg::RESULT_W - vec_pkg::DATA_W){1'b0}}, elem_result};
                sel_fire  = elem_valid;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (sel_fire) begin
            result <= sel_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sel_fire;
        end
    end

endmodule

/* src/vec_core_top.sv */
`timescale 1ns/1ps

module vec_core_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cfg_write,
    input  vec_pkg::op_e                  cfg_op,
    input  logic [vec_pkg::LEN_W-1:0]     cfg_len,
    input  logic                          data_valid,
    input  logic                          src_sel,
    input  logic [vec_pkg::DATA_W-1:0]    data_a,
    input  logic [vec_pkg::DATA_W-1:0]    data_b,
    output logic [vec_pkg::RESULT_W-1:0]  result,
    output logic                          result_valid,
    output logic                          busy
);

    vec_pkg::op_e                 op;
    logic [5:0]                   enables;
    logic                         elem_strobe;
    logic                         first;
    logic                         last;
    logic [vec_pkg::DATA_W-1:0]   elem_result;
    logic                         elem_valid;
    logic [vec_pkg::MAN_W-1:0]    man_sum;
    logic [vec_pkg::RESULT_W-1:0] dot_sum;
    logic [vec_pkg::RESULT_W-1:0] sq_sum;
    logic                         accum_done;
    logic [vec_pkg::DATA_W-1:0]   root;
    logic                         sqrt_done;

    op_config u_op_config (
        .clk         (clk),
        .rst         (rst),
        .cfg_write   (cfg_write),
        .cfg_op      (cfg_op),
        .cfg_len     (cfg_len),
        .data_valid  (data_valid),
        .busy        (busy),
        .op          (op),
        .enables     (enables),
        .elem_strobe (elem_strobe),
        .first       (first),
        .last        (last)
    );

    // Lower enables bits are the element-wise group
    elem_ops u_elem_ops (
        .clk         (clk),
        .rst         (rst),
        .enables     (enables[2:0]),
        .elem_strobe (elem_strobe),
        .src_sel     (src_sel),
        .data_a      (data_a),
        .data_b      (data_b),
        .elem_result (elem_result),
        .elem_valid  (elem_valid)
    );

    vec_accum u_vec_accum (
        .clk         (clk),
        .rst         (rst),
        .cfg_write   (cfg_write),
        .enables     (enables[5:3]),
        .elem_strobe (elem_strobe),
        .first       (first),
        .last        (last),
        .data_a      (data_a),
        .data_b      (data_b),
        .man_sum     (man_sum),
        .dot_sum     (dot_sum),
        .sq_sum      (sq_sum),
        .accum_done  (accum_done)
    );

    // Root only starts for a Euclidean vector
    int_sqrt u_int_sqrt (
        .clk       (clk),
        .rst       (rst),
        .start     (accum_done & enables[3]),
        .radicand  (sq_sum),
        .root      (root),
        .busy      (busy),
        .sqrt_done (sqrt_done)
    );

    result_select u_result_select (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .elem_result  (elem_result),
        .elem_valid   (elem_valid),
        .man_sum      (man_sum),
        .dot_sum      (dot_sum),
        .accum_done   (accum_done),
        .root         (root),
        .sqrt_done    (sqrt_done),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* dv/vec_core_tb.sv */
`timescale 1ns/1ps

module vec_core_tb;

    localparam int N = vec_pkg::MAX_LEN;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         cfg_write;
    vec_pkg::op_e                 cfg_op;
    logic [vec_pkg::LEN_W-1:0]    cfg_len;
    logic                         data_valid;
    logic                         src_sel;
    logic [vec_pkg::DATA_W-1:0]   data_a;
    logic [vec_pkg::DATA_W-1:0]   data_b;
    logic [vec_pkg::RESULT_W-1:0] result;
    logic                         result_valid;
    logic                         busy;

    logic [vec_pkg::DATA_W-1:0]   vec_a [N];
    logic [vec_pkg::DATA_W-1:0]   vec_b [N];
    logic [vec_pkg::RESULT_W-1:0] res_val [$];
    int                           res_cyc [$];
    int                           drv_cyc [$];
    int                           cycle_cnt = 0;
    int                           err_cnt = 0;
    int                           chk_cnt = 0;
    int                           test_start;
    logic [31:0]                  lcg_state = 32'hfb73;

    vec_core_top vec_core_top_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_write    (cfg_write),
        .cfg_op       (cfg_op),
        .cfg_len      (cfg_len),
        .data_valid   (data_valid),
        .src_sel      (src_sel),
        .data_a       (data_a),
        .data_b       (data_b),
        .result       (result),
        .result_valid (result_valid),
        .busy         (busy)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Monitor collects each result with its cycle count
    always @(posedge clk) begin
        if (result_valid) begin
            res_val.push_back(result);
            res_cyc.push_back(cycle_cnt);
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [vec_pkg::RESULT_W-1:0] ref_result(
            input vec_pkg::op_e op,
            input logic [vec_pkg::DATA_W-1:0] a [N],
            input logic [vec_pkg::DATA_W-1:0] b [N],
            input int len, input logic sel, input int idx);
        longint pair_sum;
        longint diff;
        longint man;
        longint dot;
        longint sq;
        longint r;
        longint t;
        int     i;
        int     k;
        pair_sum = longint'(a[idx]) + longint'(b[idx]);
        man      = 0;
        dot      = 0;
        sq       = 0;
        for (i = 0; i < len; i++) begin
            diff = longint'(a[i]) - longint'(b[i]);
            if (diff < 0) begin
                diff = -diff;
            end
            man = man + diff;
            dot = dot + longint'(a[i]) * longint'(b[i]);
            sq  = sq + diff * diff;
        end
        // Reduction sums wrap at their register widths
        man = man % (longint'(1) << vec_pkg::MAN_W);
        dot = dot % (longint'(1) << vec_pkg::RESULT_W);
        sq  = sq % (longint'(1) << vec_pkg::RESULT_W);
        // Largest root whose square still fits the sum
        r = 0;
        for (k = vec_pkg::DATA_W - 1; k >= 0; k--) begin
            t = r + (longint'(1) << k);
            if (t * t <= sq) begin
                r = t;
            end
        end
        case (op)
            vec_pkg::OP_READ: return vec_pkg::RESULT_W'(sel ? b[idx] : a[idx]);
            vec_pkg::OP_SUM:  return vec_pkg::RESULT_W'(pair_sum % 65536);
            vec_pkg::OP_AVG:  return vec_pkg::RESULT_W'(pair_sum / 2);
            vec_pkg::OP_MAN:  return vec_pkg::RESULT_W'(man);
            vec_pkg::OP_DOT:  return vec_pkg::RESULT_W'(dot);
            default:          return vec_pkg::RESULT_W'(r);
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic check_result(input string name, input logic [vec_pkg::RESULT_W-1:0] got,
                                input logic [vec_pkg::RESULT_W-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input vec_pkg::op_e got,
                            input vec_pkg::op_e exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_and_finish();
        $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic timeout(input string what);
        $display("Timeout while waiting for %s", what);
        err_cnt++;
    endtask

    task automatic wait_results(input int n, input int limit);
        int i;
        i = 0;
        while (res_val.size() < n && i < limit) begin
            tick();
            i++;
        end
        if (res_val.size() < n) begin
            timeout("results");
        end
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int i;
        i = 0;
        while (busy !== level && i < limit) begin
            tick();
            i++;
        end
        if (busy !== level) begin
            timeout(level ? "busy to rise" : "busy to fall");
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        idle(16);
        rst = 1'b0;
        check_result("result_valid", {31'b0, result_valid}, 32'h0);
        check_result("busy", {31'b0, busy}, 32'h0);
        check_op("op", vec_core_top_i.op, vec_pkg::OP_READ);
    endtask

    task automatic configure(input vec_pkg::op_e op, input int len);
        cfg_write = 1'b1;
        cfg_op    = op;
        cfg_len   = vec_pkg::LEN_W'(len);
        tick();
        cfg_write = 1'b0;
        check_op("op", vec_core_top_i.op, op);
        res_val.delete();
        res_cyc.delete();
        drv_cyc.delete();
    endtask

    task automatic fill_random(input int len);
        logic [31:0] v;
        int          i;
        for (i = 0; i < len; i++) begin
            v        = lcg_next();
            vec_a[i] = v[31:16];
            v        = lcg_next();
            vec_b[i] = v[31:16];
        end
    endtask

    task automatic send_vector(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            data_valid = 1'b1;
            data_a     = vec_a[i];
            data_b     = vec_b[i];
            drv_cyc.push_back(cycle_cnt);
            tick();
        end
        data_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////////////////////////

    task automatic run_elem(input vec_pkg::op_e op, input int len, input logic sel);
        int i;
        configure(op, len);
        src_sel = sel;
        send_vector(len);
        wait_results(len, 20);
        idle(8);
        check_result("result count", 32'(res_val.size()), 32'(len));
        for (i = 0; i < len; i++) begin
            check_result("result", res_val[i], ref_result(op, vec_a, vec_b, len, sel, i));
            check_result("result latency", 32'(res_cyc[i] - drv_cyc[i]), 32'd2);
        end
    endtask

    // Two vectors per operation
    task automatic run_reduce(input vec_pkg::op_e op, input int len);
        logic [31:0] exp_q [$];
        int          last_q [$];
        int          v;
        configure(op, len);
        for (v = 0; v < 2; v++) begin
            fill_random(len);
            exp_q.push_back(ref_result(op, vec_a, vec_b, len, 1'b0, 0));
            send_vector(len);
            last_q.push_back(drv_cyc[drv_cyc.size() - 1]);
            if (op == vec_pkg::OP_EUC) begin
                // Strobes while the root runs must be dropped
                wait_busy(1'b1, 10);
                data_valid = 1'b1;
                data_a     = 16'hffff;
                data_b     = 16'h0000;
                idle(4);
                data_valid = 1'b0;
                wait_busy(1'b0, 40);
            end
        end
        wait_results(2, 40);
        idle(8);
        check_result("result count", 32'(res_val.size()), 32'd2);
        for (v = 0; v < 2; v++) begin
            check_result("result", res_val[v], exp_q[v]);
            if (op != vec_pkg::OP_EUC) begin
                check_result("result latency", 32'(res_cyc[v] - last_q[v]), 32'd3);
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s done, %0d errors", name, err_cnt - test_start);
        test_start = err_cnt;
    endtask

    initial begin
        rst        = 1'b1;
        cfg_write  = 1'b0;
        cfg_op     = vec_pkg::OP_READ;
        cfg_len    = '0;
        data_valid = 1'b0;
        src_sel    = 1'b0;
        data_a     = '0;
        data_b     = '0;
        test_start = 0;
        apply_reset();

        fill_random(8);
        run_elem(vec_pkg::OP_READ, 8, 1'b0);
        run_elem(vec_pkg::OP_READ, 8, 1'b1);
        end_test("read");

        // All-ones pairs exercise the wrap and the carry of the average
        fill_random(16);
        for (int i = 0; i < 16; i += 4) begin
            vec_a[i]     = 16'hffff;
            vec_b[i]     = 16'hffff;
            vec_a[i + 1] = 16'hffff;
            vec_b[i + 1] = 16'h0001;
        end
        run_elem(vec_pkg::OP_SUM, 16, 1'b0);
        run_elem(vec_pkg::OP_AVG, 16, 1'b0);
        end_test("sum and average");

        run_reduce(vec_pkg::OP_DOT, 32);
        run_reduce(vec_pkg::OP_MAN, 32);
        end_test("dot and manhattan");

        run_reduce(vec_pkg::OP_EUC, 1);
        run_reduce(vec_pkg::OP_EUC, 5);
        run_reduce(vec_pkg::OP_EUC, 64);
        end_test("euclidean");

        // Partial vector abandoned by a new configuration
        configure(vec_pkg::OP_DOT, 16);
        fill_random(16);
        send_vector(7);
        configure(vec_pkg::OP_DOT, 12);
        fill_random(12);
        send_vector(12);
        wait_results(1, 20);
        idle(8);
        check_result("result count", 32'(res_val.size()), 32'd1);
        check_result("result", res_val[0], ref_result(vec_pkg::OP_DOT, vec_a, vec_b, 12, 1'b0, 0));
        // Reset while the root is running
        configure(vec_pkg::OP_EUC, 4);
        fill_random(4);
        send_vector(4);
        wait_busy(1'b1, 10);
        apply_reset();
        idle(24);
        check_result("result count", 32'(res_val.size()), 32'd0);
        end_test("reconfig and reset");

        report_and_finish();
    end

endmodule

/* filelist.f */
src/vec_pkg.sv
src/op_config.sv
src/elem_ops.sv
src/vec_accum.sv
src/int_sqrt.sv
src/result_select.sv
src/vec_core_top.sv
dv/vec_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the vector core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module vec_core_tb -f filelist.f -o vec_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vec_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
